/* hw/bank_arb_cfg.svh */
/*
    Build-time sizes for the shared-bank subsystem.
    ARB_QUEUE_DEPTH must be a power of two so the queue pointers wrap freely.
    ARB_REQ_COUNT must be at least 2.
*/

`ifndef BANK_ARB_CFG_SVH
`define BANK_ARB_CFG_SVH

// Requestors and per-requestor queue entries.
`define ARB_REQ_COUNT   4
`define ARB_QUEUE_DEPTH 4

// Bank geometry: 2**ARB_ADDR_W words of ARB_DATA_W bits.
`define ARB_ADDR_W      6
`define ARB_DATA_W      16

`endif

/* hw/bank_arb_pkg.sv */
/*
    Types shared by the queues, the arbiter and the bank.
    Widths follow the macros in the cfg header.
*/

`include "bank_arb_cfg.svh"

package bank_arb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bank_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Width-derived types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [$clog2(`ARB_REQ_COUNT)-1:0] req_idx_t;  // Winning requestor.
    typedef logic [`ARB_ADDR_W-1:0]            bank_addr_t;
    typedef logic [`ARB_DATA_W-1:0]            bank_data_t;

endpackage

/* hw/pe_lsb.sv */
/*
    LSB-first priority encoder.
    WIDTH must be 2 or more. All-zero input gives all-zero outputs.
    cold_ack_mask marks every position above the winning bit.
*/

`timescale 1ns/1ns

module pe_lsb #(
    parameter int  WIDTH = 4,
    localparam int IDX_W = $clog2(WIDTH)
) (
    input  logic [WIDTH-1:0] req_vec,
    output logic [WIDTH-1:0] ack_one_hot,
    output logic [WIDTH-1:0] cold_ack_mask,
    output logic [IDX_W-1:0] ack_index
);

    // Walk upward from bit 0. The first set bit wins and every bit after it
    // goes into the cold mask.
    always_comb begin
        logic found;

        found         = 1'b0;
        ack_one_hot   = '0;
        cold_ack_mask = '0;
        ack_index     = '0;

        for (int i = 0; i < WIDTH; i++) begin
            if (found) begin
                cold_ack_mask[i] = 1'b1;
            end
            else if (req_vec[i]) begin
                ack_one_hot[i] = 1'b1;
                ack_index      = IDX_W'(i);
                found          = 1'b1;
            end
        end
    end

endmodule

/* hw/arbiter_rr.sv */
/*
    Round-robin arbiter over the queue non-empty flags.
    Grant is combinational and only given while ack_ready is high.
    The rotation point moves only on a real grant, so idle cycles keep it.
*/

`timescale 1ns/1ns

`include "bank_arb_cfg.svh"

module arbiter_rr
    import bank_arb_pkg::*;
(
    input  logic                      CLK,
    input  logic                      nRST,

    input  logic [`ARB_REQ_COUNT-1:0] req_vec,
    output logic                      req_present,

    input  logic                      ack_ready,
    output logic [`ARB_REQ_COUNT-1:0] ack_one_hot,
    output req_idx_t                  ack_index
);

    localparam int N = `ARB_REQ_COUNT;

    logic [N-1:0] last_mask;       // Positions above the last winner.
    logic [N-1:0] cold_ack_mask;

    logic [N-1:0] masked_req_vec;
    logic [N-1:0] masked_ack_one_hot;
    logic [N-1:0] masked_cold_ack_mask;
    req_idx_t     masked_ack_index;

    logic [N-1:0] unmasked_ack_one_hot;
    logic [N-1:0] unmasked_cold_ack_mask;
    req_idx_t     unmasked_ack_index;

    assign masked_req_vec = req_vec & last_mask;

    pe_lsb #(.WIDTH(N)) masked_pe (
        .req_vec       (masked_req_vec),
        .ack_one_hot   (masked_ack_one_hot),
        .cold_ack_mask (masked_cold_ack_mask),
        .ack_index     (masked_ack_index)
    );

    // Wrap-around search when nothing is left above the last winner.
    pe_lsb #(.WIDTH(N)) unmasked_pe (
        .req_vec       (req_vec),
        .ack_one_hot   (unmasked_ack_one_hot),
        .cold_ack_mask (unmasked_cold_ack_mask),
        .ack_index     (unmasked_ack_index)
    );

    always_comb begin
        req_present = |req_vec;
        if (|masked_req_vec) begin
            ack_one_hot   = masked_ack_one_hot & {N{ack_ready}};
            cold_ack_mask = masked_cold_ack_mask;
            ack_index     = masked_ack_index;
        end
        else begin
            ack_one_hot   = unmasked_ack_one_hot & {N{ack_ready}};
            cold_ack_mask = unmasked_cold_ack_mask;
            ack_index     = unmasked_ack_index;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_mask <= '0;
        end
        else if (ack_ready && req_present) begin
            last_mask <= cold_ack_mask;
        end
    end

    a_grant_onehot_ready : assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(ack_one_hot) && (ack_ready || ack_one_hot == '0));

endmodule

/* hw/req_queue.sv */
/*
    Per-requestor queue of bank operations.
    Head fields are valid only while not_empty is high.
    Pushing while full or popping while empty is illegal.
*/

`timescale 1ns/1ns

`include "bank_arb_cfg.svh"

module req_queue
    import bank_arb_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,

    input  logic       push,
    input  bank_op_t   push_op,
    input  bank_addr_t push_addr,
    input  bank_data_t push_data,

    input  logic       pop,
    output logic       not_empty,
    output logic       full,
    output bank_op_t   head_op,
    output bank_addr_t head_addr,
    output bank_data_t head_data
);

    localparam int DEPTH = `ARB_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    bank_op_t   op_mem   [DEPTH];
    bank_addr_t addr_mem [DEPTH];
    bank_data_t data_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;     // One extra bit to tell full from empty.

    assign not_empty = (count != '0);
    assign full      = (count == (PTR_W+1)'(DEPTH));

    assign head_op   = op_mem[rd_ptr];
    assign head_addr = addr_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage and pointers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLK) begin
        if (push) begin
            op_mem[wr_ptr]   <= push_op;
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither leave it.
            endcase
        end
    end

    a_no_push_full : assert property (@(posedge CLK) disable iff (!nRST)
        !(push && full));

    // The pop comes from the arbiter, so this checks its grant against us.
    a_no_pop_empty : assert property (@(posedge CLK) disable iff (!nRST)
        !(pop && !not_empty));

endmodule

/* hw/shared_bank.sv */
/*
    Single-port storage bank, one granted operation per cycle.
    Contents are not cleared by reset and read back unknown until written.
    Read data returns one cycle after the grant edge; writes give no response.
*/

`timescale 1ns/1ns

`include "bank_arb_cfg.svh"

module shared_bank
    import bank_arb_pkg::*;
(
    input  logic       CLK,
    input  logic       nRST,

    input  logic       hold,
    input  logic       req_present,
    input  req_idx_t   grant_idx,
    input  bank_op_t   op,
    input  bank_addr_t addr,
    input  bank_data_t wdata,
    output logic       ready,

    output logic       rsp_valid,
    output req_idx_t   rsp_idx,
    output bank_data_t rsp_data
);

    localparam int WORDS = 2 ** `ARB_ADDR_W;

    bank_data_t mem [WORDS];
    logic       exec;

    assign ready = !hold;
    assign exec  = req_present && ready;    // Same condition the arbiter grants on.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Array access.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLK) begin
        if (exec && op == OP_WRITE) begin
            mem[addr] <= wdata;
        end
        if (exec && op == OP_READ) begin
            rsp_data <= mem[addr];
            rsp_idx  <= grant_idx;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rsp_valid <= 1'b0;
        end
        else begin
            rsp_valid <= exec && (op == OP_READ);
        end
    end

    // A granted operation must come from a filled queue slot.
    a_exec_known : assert property (@(posedge CLK) disable iff (!nRST)
        exec |-> !$isunknown({grant_idx, op, addr}));

endmodule

/* hw/bank_arb_top.sv */
/*
    Four operation queues sharing one storage bank through a round-robin arbiter.
    Never push into a queue whose full bit is high.
    Uncontended read latency is 2 cycles from push to rsp_valid.
*/

`timescale 1ns/1ns

`include "bank_arb_cfg.svh"

module bank_arb_top
    import bank_arb_pkg::*;
(
    input  logic                      CLK,
    input  logic                      nRST,

    input  logic [`ARB_REQ_COUNT-1:0] push,
    input  bank_op_t                  push_op   [`ARB_REQ_COUNT],
    input  bank_addr_t                push_addr [`ARB_REQ_COUNT],
    input  bank_data_t                push_data [`ARB_REQ_COUNT],
    output logic [`ARB_REQ_COUNT-1:0] full,

    input  logic                      hold,

    output logic                      rsp_valid,
    output req_idx_t                  rsp_idx,
    output bank_data_t                rsp_data
);

    localparam int N = `ARB_REQ_COUNT;

    logic [N-1:0] not_empty;
    bank_op_t     head_op   [N];
    bank_addr_t   head_addr [N];
    bank_data_t   head_data [N];

    logic [N-1:0] ack_one_hot;
    req_idx_t     ack_index;
    logic         req_present;
    logic         ready;

    for (genvar i = 0; i < N; i++) begin : g_queue
        req_queue i_req_queue (
            .CLK       (CLK),
            .nRST      (nRST),
            .push      (push[i]),
            .push_op   (push_op[i]),
            .push_addr (push_addr[i]),
            .push_data (push_data[i]),
            .pop       (ack_one_hot[i]),
            .not_empty (not_empty[i]),
            .full      (full[i]),
            .head_op   (head_op[i]),
            .head_addr (head_addr[i]),
            .head_data (head_data[i])
        );
    end

    arbiter_rr i_arbiter_rr (
        .CLK         (CLK),
        .nRST        (nRST),
        .req_vec     (not_empty),
        .req_present (req_present),
        .ack_ready   (ready),
        .ack_one_hot (ack_one_hot),
        .ack_index   (ack_index)
    );

    // The winning head goes straight to the bank.
    shared_bank i_shared_bank (
        .CLK         (CLK),
        .nRST        (nRST),
        .hold        (hold),
        .req_present (req_present),
        .grant_idx   (ack_index),
        .op          (head_op[ack_index]),
        .addr        (head_addr[ack_index]),
        .wdata       (head_data[ack_index]),
        .ready       (ready),
        .rsp_valid   (rsp_valid),
        .rsp_idx     (rsp_idx),
        .rsp_data    (rsp_data)
    );

endmodule

/* verification/tb_clk_gen.sv */
/*
    Clock and reset source for the testbench.
    CLK has a 4 ns period. nRST is held low for the first 5 rising edges.
*/

`timescale 1ns/1ns

module tb_clk_gen (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;                  // Released right after an edge.
    end

endmodule

/* verification/bank_arb_tb.sv */
/*
    Directed testbench for the shared-bank subsystem.
    A cycle model of queues, round-robin pointer and bank predicts every read.
    Stimulus only pushes into a queue that the model shows has room.
*/

`timescale 1ns/1ns

`include "bank_arb_cfg.svh"

module bank_arb_tb
    import bank_arb_pkg::*;
();

    localparam int N          = `ARB_REQ_COUNT;
    localparam int DEPTH      = `ARB_QUEUE_DEPTH;
    localparam int TEST_OPS   = 88;    // The random test counts one op per cycle.
    localparam int MAX_CYCLES = 40 * TEST_OPS + 500;

    logic         CLK;
    logic         nRST;
    logic [N-1:0] push;
    bank_op_t     push_op   [N];
    bank_addr_t   push_addr [N];
    bank_data_t   push_data [N];
    logic [N-1:0] full;
    logic         hold;
    logic         rsp_valid;
    req_idx_t     rsp_idx;
    bank_data_t   rsp_data;

    bank_data_t   shadow [2 ** `ARB_ADDR_W];
    bank_op_t     m_op   [N][DEPTH];
    bank_addr_t   m_addr [N][DEPTH];
    bank_data_t   m_data [N][DEPTH];
    int           m_head [N];
    int           m_cnt  [N];
    int           last_win;
    req_idx_t     exp_idx [$];
    bank_data_t   exp_data [$];

    bank_addr_t   pool      [8];    // Addresses written by the read-back test.
    bank_data_t   pool_data [8];
    req_idx_t     got_idx   [8];
    bank_data_t   got_data  [8];
    int           got_cyc   [8];
    int           seed       = 32'hc030;
    int           cycle      = 0;
    int           n_mismatch = 0;
    int           n_fail     = 0;

    tb_clk_gen i_tb_clk_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    bank_arb_top i_bank_arb_top (
        .CLK       (CLK),
        .nRST      (nRST),
        .push      (push),
        .push_op   (push_op),
        .push_addr (push_addr),
        .push_data (push_data),
        .full      (full),
        .hold      (hold),
        .rsp_valid (rsp_valid),
        .rsp_idx   (rsp_idx),
        .rsp_data  (rsp_data)
    );

    always @(posedge CLK) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles before the tests finished", cycle);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_data(input bank_data_t got, input bank_data_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic check_idx(input req_idx_t got, input req_idx_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %b, expected %b", $time, what, got, exp);
            n_mismatch++;
        end
    endtask

    // Inputs seen at a falling edge are what the DUT samples at the next rising
    // edge, so the model steps that edge here. Responses come from the last one.
    always @(negedge CLK) begin
        int w;
        int t;
        if (nRST) begin
            if (rsp_valid && exp_idx.size() == 0) begin
                $display("Read response from requestor %0d with no read outstanding", rsp_idx);
                n_fail++;
            end
            else if (rsp_valid) begin
                check_idx(rsp_idx, exp_idx.pop_front(), "response index");
                check_data(rsp_data, exp_data.pop_front(), "response data");
            end
            for (int j = 0; j < N; j++) begin
                check_flag(full[j], m_cnt[j] == DEPTH, $sformatf("queue %0d full", j));
            end
            w = -1;
            for (int j = 1; j <= N && !hold; j++) begin
                t = (last_win + j) % N;    // Search starts just above the last winner.
                if (w < 0 && m_cnt[t] != 0) w = t;
            end
            if (w >= 0) begin
                t = m_head[w];
                if (m_op[w][t] == OP_WRITE) begin
                    shadow[m_addr[w][t]] = m_data[w][t];
                end
                else begin
                    exp_idx.push_back(req_idx_t'(w));
                    exp_data.push_back(shadow[m_addr[w][t]]);
                end
                m_head[w] = (t + 1) % DEPTH;
                m_cnt[w]--;
                last_win = w;
            end
            for (int j = 0; j < N; j++) begin
                if (push[j]) begin
                    t = (m_head[j] + m_cnt[j]) % DEPTH;
                    m_op[j][t]   = push_op[j];
                    m_addr[j][t] = push_addr[j];
                    m_data[j][t] = push_data[j];
                    m_cnt[j]++;
                end
            end
        end
    end

    function automatic int outstanding();
        int total;
        total = exp_idx.size();
        for (int i = 0; i < N; i++) begin
            total += m_cnt[i];
        end
        return total;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stage(input int i, input bank_op_t op, input bank_addr_t a,
                         input bank_data_t d);
        push_op[i]   <= op;
        push_addr[i] <= a;
        push_data[i] <= d;
    endtask

    task automatic push_one(input int i, input bank_op_t op, input bank_addr_t a,
                            input bank_data_t d);
        @(posedge CLK);
        while (m_cnt[i] >= DEPTH) begin
            push <= '0;
            @(posedge CLK);
        end
        stage(i, op, a, d);
        push <= N'(1) << i;
    endtask

    task automatic stop_push();
        @(posedge CLK);
        push <= '0;
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (outstanding() != 0 && waited < limit) begin
            @(posedge CLK);
            waited++;
        end
        if (outstanding() != 0) begin
            $display("Gave up waiting with %0d operations or reads still pending", outstanding());
            n_fail++;
        end
    endtask

    task automatic collect_rsp(input int n);
        int k;
        int waited;
        k = 0;
        waited = 0;
        while (k < n && waited < 40 * n) begin
            @(negedge CLK);
            waited++;
            if (rsp_valid) begin
                got_idx[k]  = rsp_idx;
                got_data[k] = rsp_data;
                got_cyc[k]  = waited;    // Falling edges since the push was sampled.
                k++;
            end
        end
        if (k < n) begin
            $display("Only %0d of %0d read responses arrived", k, n);
            n_fail++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reset_order();
        @(posedge CLK);
        for (int i = 0; i < N; i++) begin
            stage(i, OP_READ, bank_addr_t'(i), '0);
        end
        push <= '1;
        stop_push();
        collect_rsp(N);
        for (int i = 0; i < N; i++) begin
            check_idx(got_idx[i], req_idx_t'(i), "order after reset");
        end
        if (got_cyc[N-1] - got_cyc[0] != N - 1) begin
            $display("Responses after reset did not arrive on consecutive cycles");
            n_fail++;
        end
    endtask

    task automatic rotation();
        push_one(1, OP_READ, 6'd9, '0);
        stop_push();
        wait_drain(40);
        @(posedge CLK);
        stage(0, OP_READ, 6'd1, '0);
        stage(1, OP_READ, 6'd2, '0);
        stage(3, OP_READ, 6'd3, '0);
        push <= 4'b1011;
        stop_push();
        collect_rsp(3);
        check_idx(got_idx[0], 2'd3, "rotation first");
        check_idx(got_idx[1], 2'd0, "rotation second");
        check_idx(got_idx[2], 2'd1, "rotation third");
    endtask

    task automatic read_after_write();
        for (int k = 0; k < 8; k++) begin
            pool[k]      = {3'($random(seed)), 3'(k)};
            pool_data[k] = bank_data_t'($random(seed));
            push_one(2, OP_WRITE, pool[k], pool_data[k]);
        end
        stop_push();
        wait_drain(40 * 8);
        for (int k = 0; k < 8; k++) begin
            push_one(2, OP_READ, pool[k], '0);
            stop_push();
            collect_rsp(1);
            check_idx(got_idx[0], 2'd2, "read-back index");
            check_data(got_data[0], pool_data[k], "read-back data");
            if (got_cyc[0] != 2) begin
                $display("Mismatch at %0t ns: read latency %0d, expected 2", $time, got_cyc[0]);
                n_mismatch++;
            end
        end
    endtask

    task automatic hold_backpressure();
        @(posedge CLK);
        hold <= 1'b1;
        for (int k = 0; k < DEPTH; k++) begin
            push_one(0, (k % 2) ? OP_READ : OP_WRITE, pool[k / 2], bank_data_t'($random(seed)));
        end
        stop_push();
        @(negedge CLK);
        if (!full[0]) begin
            $display("Queue 0 did not raise full with %0d entries under hold", DEPTH);
            n_fail++;
        end
        repeat (4) begin
            @(negedge CLK);
            if (rsp_valid) begin
                $display("A read response came out while hold was high");
                n_fail++;
            end
        end
        @(posedge CLK);
        hold <= 1'b0;
        wait_drain(40 * DEPTH);
    endtask

    task automatic random_traffic(input int cycles);
        logic [N-1:0] mask;
        repeat (cycles) begin
            @(posedge CLK);
            mask = '0;
            for (int i = 0; i < N; i++) begin
                if ({$random(seed)} % 3 == 0 && m_cnt[i] < DEPTH) begin
                    stage(i, ({$random(seed)} % 2) ? OP_WRITE : OP_READ,
                          pool[{$random(seed)} % 8], bank_data_t'($random(seed)));
                    mask[i] = 1'b1;
                end
            end
            push <= mask;
            hold <= ({$random(seed)} % 5 == 0);
        end
        stop_push();
        hold <= 1'b0;
        wait_drain(40 * N * DEPTH);
    endtask

    initial begin
        push     = '0;
        hold     = 1'b0;
        last_win = N - 1;    // First search then starts at requestor 0.
        for (int i = 0; i < N; i++) begin
            push_op[i]   = OP_READ;
            push_addr[i] = '0;
            push_data[i] = '0;
            m_head[i]    = 0;
            m_cnt[i]     = 0;
        end
        wait (nRST === 1'b1);
        reset_order();
        rotation();
        read_after_write();
        hold_backpressure();
        random_traffic(60);
        $display("Errors: %0d mismatches, %0d other failures", n_mismatch, n_fail);
        if (n_mismatch == 0 && n_fail == 0) begin
            $display("TEST PASSED");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hw
hw/bank_arb_pkg.sv
hw/pe_lsb.sv
hw/arbiter_rr.sv
hw/req_queue.sv
hw/shared_bank.sv
hw/bank_arb_top.sv
verification/tb_clk_gen.sv
verification/bank_arb_tb.sv

/* Bender.yml */
package:
  name: bank_arb

export_include_dirs:
  - hw

sources:
  - files:
      - hw/bank_arb_pkg.sv
      - hw/pe_lsb.sv
      - hw/arbiter_rr.sv
      - hw/req_queue.sv
      - hw/shared_bank.sv
      - hw/bank_arb_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/bank_arb_tb.sv
